/* rtl/channel_counter_bank.sv */
// channel_counter_bank module, partial sums, per-channel counters and window snapshot
`timescale 1ns/10ps
`default_nettype none

module channel_counter_bank #(
    parameter int NUM_LANES    = countrate_pkg::DEFAULT_NUM_LANES,
    parameter int NUM_CHANNELS = countrate_pkg::DEFAULT_NUM_CHANNELS
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n_i,
    input  wire logic                                clear_i,
    input  wire logic [NUM_CHANNELS-1:0][NUM_LANES-1:0] cur_hits_i,
    input  wire logic [NUM_CHANNELS-1:0][NUM_LANES-1:0] next_hits_i,
    input  wire logic                                close_i,
    output countrate_pkg::count_t [NUM_CHANNELS-1:0] count_data_o,
    output logic                                     count_valid_o
);

    // enough bits for every lane hitting one channel
    localparam int SUM_WIDTH = $clog2(NUM_LANES + 1);

    typedef logic [SUM_WIDTH-1:0] sum_t;

    sum_t [NUM_CHANNELS-1:0] cur_sum_q;
    sum_t [NUM_CHANNELS-1:0] next_sum_q;
    logic close_q;
    countrate_pkg::count_t [NUM_CHANNELS-1:0] counter_q;
    countrate_pkg::count_t [NUM_CHANNELS-1:0] snap_q;
    logic valid_q;

    // number of lanes set in one channel mask
    function automatic sum_t popcount(input logic [NUM_LANES-1:0] mask);
        sum_t total;
        total = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            total = total + sum_t'(mask[i]);
        end
        return total;
    endfunction

    // stage 1, partial sums with close kept in step
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cur_sum_q  <= '0;
            next_sum_q <= '0;
            close_q    <= 1'b0;
        end else if (clear_i) begin
            cur_sum_q  <= '0;
            next_sum_q <= '0;
            close_q    <= 1'b0;
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                cur_sum_q[c]  <= popcount(cur_hits_i[c]);
                next_sum_q[c] <= popcount(next_hits_i[c]);
            end
            close_q <= close_i;
        end
    end

    // stage 2, accumulate, on close restart from the next-window sum
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            counter_q <= '0;
            valid_q   <= 1'b0;
        end else if (clear_i) begin
            counter_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (close_q) begin
                    counter_q[c] <= countrate_pkg::count_t'(next_sum_q[c]);
                end else begin
                    counter_q[c] <= counter_q[c] + countrate_pkg::count_t'(cur_sum_q[c]);
                end
            end
            valid_q <= close_q;
        end
    end

    // closing window total includes the tags of the closing beat
    always_ff @(posedge clk) begin
        if (close_q) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                snap_q[c] <= counter_q[c] + countrate_pkg::count_t'(cur_sum_q[c]);
            end
        end
    end

    assign count_data_o  = snap_q;
    // no snapshot leaves while the measurement is being cleared
    assign count_valid_o = valid_q & ~clear_i;

endmodule

`default_nettype wire

/* rtl/countrate_pkg.sv */
// shared widths, vector typedefs, default parameter values and tracker state enum
`default_nettype none

package countrate_pkg;

    // timestamp width, also used for window bounds and window size
    localparam int TAG_WIDTH = 64;

    // channel number field carried with every tag
    localparam int CHANNEL_WIDTH = 6;

    // width of one per-channel counter and of its snapshot
    localparam int COUNTER_WIDTH = 32;

    // tags per input beat
    localparam int DEFAULT_NUM_LANES = 4;

    // counted channels, anything above acts as keep-alive
    localparam int DEFAULT_NUM_CHANNELS = 16;

    // one timestamp or window bound
    typedef logic [TAG_WIDTH-1:0] tag_time_t;

    // one channel number
    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

    // one counter or snapshot value
    typedef logic [COUNTER_WIDTH-1:0] count_t;

    // measurement control states
    // IDLE waits for start, ARMED waits for the opening beat
    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        MEASURING
    } run_state_t;

endpackage

`default_nettype wire

/* rtl/countrate_top.sv */
// countrate_top module, plain-port top level wiring tracker, decoder and counter bank
`timescale 1ns/10ps
`default_nettype none

module countrate_top #(
    parameter int NUM_LANES    = countrate_pkg::DEFAULT_NUM_LANES,
    parameter int NUM_CHANNELS = countrate_pkg::DEFAULT_NUM_CHANNELS
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n_i,
    input  wire logic [NUM_LANES-1:0]                tag_valid_i,
    input  countrate_pkg::tag_time_t [NUM_LANES-1:0] tag_time_i,
    input  countrate_pkg::channel_t [NUM_LANES-1:0]  tag_channel_i,
    output logic                                     tag_ready_o,
    input  countrate_pkg::tag_time_t                 window_size_i,
    input  wire logic                                start_i,
    input  wire logic                                clear_i,
    output countrate_pkg::count_t [NUM_CHANNELS-1:0] count_data_o,
    output logic                                     count_valid_o
);

    // decoder to counter bank, one lane mask per channel
    logic [NUM_CHANNELS-1:0][NUM_LANES-1:0] cur_hits;
    logic [NUM_CHANNELS-1:0][NUM_LANES-1:0] next_hits;
    logic close;

    // bounds and advance/ready between tracker and decoder
    window_if #(.NUM_LANES(NUM_LANES)) u_win ();

    window_tracker #(
        .NUM_LANES    (NUM_LANES)
    ) u_tracker (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .tag_valid_i  (tag_valid_i),
        .tag_time_i   (tag_time_i),
        .window_size_i(window_size_i),
        .start_i      (start_i),
        .clear_i      (clear_i),
        .win          (u_win.tracker)
    );

    tag_window_decode #(
        .NUM_LANES    (NUM_LANES),
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .tag_valid_i  (tag_valid_i),
        .tag_time_i   (tag_time_i),
        .tag_channel_i(tag_channel_i),
        .clear_i      (clear_i),
        .win          (u_win.decoder),
        .cur_hits_o   (cur_hits),
        .next_hits_o  (next_hits),
        .close_o      (close)
    );

    channel_counter_bank #(
        .NUM_LANES    (NUM_LANES),
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_bank (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .clear_i      (clear_i),
        .cur_hits_i   (cur_hits),
        .next_hits_i  (next_hits),
        .close_i      (close),
        .count_data_o (count_data_o),
        .count_valid_o(count_valid_o)
    );

    assign tag_ready_o = u_win.tag_ready;

endmodule

`default_nettype wire

/* rtl/tag_window_decode.sv */
// tag_window_decode module, lane classification against window bounds and hit mask registers
`timescale 1ns/10ps
`default_nettype none

module tag_window_decode #(
    parameter int NUM_LANES    = countrate_pkg::DEFAULT_NUM_LANES,
    parameter int NUM_CHANNELS = countrate_pkg::DEFAULT_NUM_CHANNELS
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n_i,
    input  wire logic [NUM_LANES-1:0]                  tag_valid_i,
    input  countrate_pkg::tag_time_t [NUM_LANES-1:0]   tag_time_i,
    input  countrate_pkg::channel_t [NUM_LANES-1:0]    tag_channel_i,
    input  wire logic                                  clear_i,
    window_if.decoder                                  win,
    output logic [NUM_CHANNELS-1:0][NUM_LANES-1:0]     cur_hits_o,
    output logic [NUM_CHANNELS-1:0][NUM_LANES-1:0]     next_hits_o,
    output logic                                       close_o
);

    localparam int SIGN_BIT = countrate_pkg::TAG_WIDTH - 1;

    // differences to both bounds, wrap safe
    countrate_pkg::tag_time_t [NUM_LANES-1:0] diff_cur;
    countrate_pkg::tag_time_t [NUM_LANES-1:0] diff_next;
    logic [NUM_LANES-1:0] past_cur;
    logic [NUM_LANES-1:0] past_next;
    logic [NUM_LANES-1:0] active_mask;
    logic [NUM_LANES-1:0] late;
    logic [NUM_LANES-1:0] lane_cur;
    logic [NUM_LANES-1:0] lane_next;
    logic [NUM_LANES-1:0] done_q;
    logic [NUM_LANES-1:0] done_n;
    logic active;
    logic accept;
    logic [NUM_CHANNELS-1:0][NUM_LANES-1:0] cur_hits_n;
    logic [NUM_CHANNELS-1:0][NUM_LANES-1:0] next_hits_n;

    // clear wins over a running measurement in the same cycle
    assign active      = win.measuring & ~clear_i;
    assign active_mask = tag_valid_i & {NUM_LANES{active}};

    // sign bit clear means the tag is at or past that bound
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            diff_cur[i]  = tag_time_i[i] - win.window_end;
            diff_next[i] = tag_time_i[i] - win.next_end;
            past_cur[i]  = ~diff_cur[i][SIGN_BIT];
            past_next[i] = ~diff_next[i][SIGN_BIT];
        end
    end

    // a tag beyond the next window holds the beat
    assign late          = active_mask & past_next;
    assign win.tag_ready = ~|late;

    // any tag past the current window moves the bounds, keep-alives included
    assign win.lane_ahead = active_mask & past_cur;

    assign accept = |tag_valid_i & win.tag_ready;

    // lanes still owed a count for this beat
    // a held beat is seen several times, done_q stops a second count
    assign lane_cur  = active_mask & ~done_q & ~past_cur;
    assign lane_next = active_mask & ~done_q & past_cur & ~past_next;

    // accepted beat frees the lanes for the following beat
    assign done_n = accept ? '0 : (done_q | lane_cur | lane_next);

    // one-hot per channel, out-of-range channels match no row
    always_comb begin
        cur_hits_n  = '0;
        next_hits_n = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                if (tag_channel_i[i] == countrate_pkg::channel_t'(c)) begin
                    cur_hits_n[c][i]  = lane_cur[i];
                    next_hits_n[c][i] = lane_next[i];
                end
            end
        end
    end

    // hit masks and close leave one cycle after the beat
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cur_hits_o  <= '0;
            next_hits_o <= '0;
            close_o     <= 1'b0;
            done_q      <= '0;
        end else if (clear_i) begin
            cur_hits_o  <= '0;
            next_hits_o <= '0;
            close_o     <= 1'b0;
            done_q      <= '0;
        end else begin
            cur_hits_o  <= cur_hits_n;
            next_hits_o <= next_hits_n;
            close_o     <= win.advance;
            done_q      <= done_n;
        end
    end

endmodule

`default_nettype wire

/* rtl/window_if.sv */
// window_if interface with window bounds and advance/ready control, tracker and decoder modports
`timescale 1ns/10ps
`default_nettype none

interface window_if #(
    parameter int NUM_LANES = countrate_pkg::DEFAULT_NUM_LANES
);

    // end of the current window, exclusive
    countrate_pkg::tag_time_t window_end;
    // end of the window after it, exclusive
    countrate_pkg::tag_time_t next_end;
    // bounds are valid and tags get classified
    logic measuring;

    // lanes holding a valid tag at or past window_end
    logic [NUM_LANES-1:0] lane_ahead;
    // any such lane closes the current window this cycle
    logic advance;
    // low while a tag sits two or more windows ahead
    logic tag_ready;

    assign advance = |lane_ahead;

    modport tracker (
        output window_end,
        output next_end,
        output measuring,
        input  advance,
        input  tag_ready
    );

    modport decoder (
        input  window_end,
        input  next_end,
        input  measuring,
        input  advance,
        output lane_ahead,
        output tag_ready
    );

endinterface

`default_nettype wire

/* rtl/window_tracker.sv */
// window_tracker module, start/clear FSM and current and next window end registers
`timescale 1ns/10ps
`default_nettype none

module window_tracker #(
    parameter int NUM_LANES = countrate_pkg::DEFAULT_NUM_LANES
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n_i,
    input  wire logic [NUM_LANES-1:0]                tag_valid_i,
    input  countrate_pkg::tag_time_t [NUM_LANES-1:0] tag_time_i,
    input  countrate_pkg::tag_time_t                 window_size_i,
    input  wire logic                                start_i,
    input  wire logic                                clear_i,
    window_if.tracker                                win
);

    countrate_pkg::run_state_t state_q;
    countrate_pkg::tag_time_t  open_time;
    countrate_pkg::tag_time_t  window_end_q;
    countrate_pkg::tag_time_t  next_end_q;
    logic open_beat;
    logic shift;

    // lowest-index valid lane, scanned downwards so lane 0 wins
    always_comb begin
        open_time = tag_time_i[0];
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (tag_valid_i[i]) begin
                open_time = tag_time_i[i];
            end
        end
    end

    // first accepted beat after start opens window 0
    assign open_beat = (state_q == countrate_pkg::ARMED) & |tag_valid_i
                       & win.tag_ready & ~clear_i;
    assign shift     = (state_q == countrate_pkg::MEASURING) & win.advance & ~clear_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= countrate_pkg::IDLE;
        end else if (clear_i) begin
            state_q <= countrate_pkg::IDLE;
        end else begin
            case (state_q)
                countrate_pkg::IDLE: begin
                    if (start_i) begin
                        state_q <= countrate_pkg::ARMED;
                    end
                end
                countrate_pkg::ARMED: begin
                    if (open_beat) begin
                        state_q <= countrate_pkg::MEASURING;
                    end
                end
                countrate_pkg::MEASURING: begin
                    state_q <= countrate_pkg::MEASURING;
                end
                default: begin
                    state_q <= countrate_pkg::IDLE;
                end
            endcase
        end
    end

    // size is sampled at every update, so a new size reaches the far bound first
    always_ff @(posedge clk) begin
        if (open_beat) begin
            window_end_q <= open_time + window_size_i;
            next_end_q   <= open_time + (window_size_i << 1);
        end else if (shift) begin
            window_end_q <= next_end_q;
            next_end_q   <= next_end_q + window_size_i;
        end
    end

    assign win.window_end = window_end_q;
    assign win.next_end   = next_end_q;
    assign win.measuring  = (state_q == countrate_pkg::MEASURING);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the count-rate meter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    --top-module countrate_tb \
    -f sources.f \
    -o countrate_sim

sim_out=$(./obj_dir/countrate_sim)
echo "$sim_out"

# the run passes only when the testbench printed its pass line
if echo "$sim_out" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi

/* sources.f */
+incdir+testbench
rtl/countrate_pkg.sv
rtl/window_if.sv
rtl/window_tracker.sv
rtl/tag_window_decode.sv
rtl/channel_counter_bank.sv
rtl/countrate_top.sv
testbench/countrate_tb.sv

/* testbench/countrate_tests.svh */
// directed test tasks for counting, window crossing, gap stall, keep-alive, resize and clear, random
`ifndef COUNTRATE_TESTS_SVH
`define COUNTRATE_TESTS_SVH

    // three windows of 100 with several channels and lanes per beat
    task automatic count_basic_windows();
        int err_before;
        int stalls;
        countrate_pkg::tag_time_t base;
        countrate_pkg::tag_time_t t;
        err_before  = errors + mon_errors;
        base        = 64'd1000;
        window_size = 64'd100;
        start_run();
        // opening beat with two tags that must not be counted
        stage_lane(0, base, 0);
        stage_lane(1, base + 64'd2, 1);
        send_staged(stalls);
        for (int w = 0; w < 3; w++) begin
            for (int b = 0; b < 4; b++) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (((b + l) % 3) != 2) begin
                        t = base + countrate_pkg::tag_time_t'(w * 100 + b * 20 + l * 4 + 10);
                        stage_lane(l, t, (w + b + l) % 6);
                    end
                end
                send_staged(stalls);
                check_stalls(stalls, 0);
            end
        end
        close_and_report("basic_counting", err_before);
    endtask

    // lanes of one beat split across the window end
    task automatic split_beat_across_windows();
        int err_before;
        int stalls;
        err_before  = errors + mon_errors;
        window_size = 64'd50;
        start_run();
        stage_lane(0, 64'd0, 1);
        send_staged(stalls);
        // lanes 2 and 3 belong to window [50,100)
        stage_lane(0, 64'd40, 2);
        stage_lane(1, 64'd45, 3);
        stage_lane(2, 64'd50, 2);
        stage_lane(3, 64'd60, 4);
        send_staged(stalls);
        check_stalls(stalls, 0);
        stage_lane(0, 64'd70, 3);
        stage_lane(1, 64'd99, 2);
        stage_lane(2, 64'd100, 5);
        stage_lane(3, 64'd110, 2);
        send_staged(stalls);
        check_stalls(stalls, 0);
        // whole beat lands in the next window
        stage_lane(0, 64'd150, 0);
        stage_lane(1, 64'd151, 0);
        stage_lane(2, 64'd160, 1);
        stage_lane(3, 64'd199, 1);
        send_staged(stalls);
        check_stalls(stalls, 0);
        close_and_report("window_crossing", err_before);
    endtask

    // tags far ahead hold the beat and leave one empty snapshot per skipped window
    task automatic stall_over_gap();
        int err_before;
        int stalls;
        err_before  = errors + mon_errors;
        window_size = 64'd10;
        start_run();
        stage_lane(0, 64'd500, 0);
        send_staged(stalls);
        stage_lane(0, 64'd505, 1);
        send_staged(stalls);
        // 545 sits four windows ahead and holds the beat for three cycles
        stage_lane(0, 64'd508, 2);
        stage_lane(1, 64'd545, 7);
        send_staged(stalls);
        check_stalls(stalls, 3);
        // 600 sits six windows ahead of [540,550) and holds the beat for five cycles
        stage_lane(0, 64'd546, 7);
        stage_lane(1, 64'd600, 8);
        send_staged(stalls);
        check_stalls(stalls, 5);
        close_and_report("gap_stall", err_before);
    endtask

    // channels 16 and up close windows but never count
    task automatic pass_keep_alive_tags();
        int err_before;
        int stalls;
        err_before  = errors + mon_errors;
        window_size = 64'd20;
        start_run();
        stage_lane(0, 64'd0, 20);
        send_staged(stalls);
        stage_lane(0, 64'd5, 3);
        stage_lane(1, 64'd6, 16);
        stage_lane(2, 64'd25, 40);
        stage_lane(3, 64'd30, 63);
        send_staged(stalls);
        check_stalls(stalls, 0);
        // lone keep-alive two windows ahead
        stage_lane(0, 64'd70, 16);
        send_staged(stalls);
        check_stalls(stalls, 1);
        stage_lane(0, 64'd75, 3);
        send_staged(stalls);
        close_and_report("keep_alive", err_before);
    endtask

    // size change between beats followed by clear and a fresh start
    task automatic resize_and_clear();
        int err_before;
        int stalls;
        int seen_before;
        err_before  = errors + mon_errors;
        window_size = 64'd30;
        start_run();
        stage_lane(0, 64'd1000, 0);
        send_staged(stalls);
        stage_lane(0, 64'd1010, 1);
        stage_lane(1, 64'd1035, 2);
        send_staged(stalls);
        window_size = 64'd50;
        stage_lane(0, 64'd1070, 3);
        send_staged(stalls);
        stage_lane(0, 64'd1100, 4);
        send_staged(stalls);
        stage_lane(0, 64'd1150, 5);
        send_staged(stalls);
        wait_snapshots();
        // channel 5 is still pending when the run is cleared
        clear_run();
        seen_before = snaps_seen;
        stage_lane(0, 64'd2000, 1);
        send_staged(stalls);
        repeat (12) @(negedge clk);
        if (snaps_seen != seen_before) begin
            $display("count_valid_o pulsed after clear_i without a new start");
            errors++;
        end
        window_size = 64'd40;
        start_run();
        stage_lane(0, 64'd3000, 2);
        send_staged(stalls);
        stage_lane(0, 64'd3010, 1);
        stage_lane(1, 64'd3020, 1);
        send_staged(stalls);
        close_and_report("size_and_clear", err_before);
    endtask

    // random ordered traffic across the 64-bit wrap
    // window size changes every 25 beats
    task automatic drive_random_traffic();
        int err_before;
        int stalls;
        countrate_pkg::tag_time_t t;
        err_before  = errors + mon_errors;
        window_size = countrate_pkg::tag_time_t'($urandom_range(8, 40));
        start_run();
        t = 64'hffff_ffff_ffff_fc00;
        stage_lane(0, t, 0);
        send_staged(stalls);
        for (int b = 0; b < 150; b++) begin
            if ((b % 25) == 24) begin
                window_size = countrate_pkg::tag_time_t'($urandom_range(8, 40));
            end
            // an occasional long gap forces a stall
            if ($urandom_range(0, 9) == 0) begin
                t = t + countrate_pkg::tag_time_t'($urandom_range(0, 120));
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                t = t + countrate_pkg::tag_time_t'($urandom_range(0, 6));
                if ($urandom_range(0, 3) != 0) begin
                    stage_lane(l, t, $urandom_range(0, 19));
                end
            end
            if (stage_valid == '0) begin
                stage_lane(NUM_LANES - 1, t, $urandom_range(0, 19));
            end
            send_staged(stalls);
        end
        close_and_report("random_traffic", err_before);
    endtask

`endif

/* testbench/countrate_tb.sv */
// countrate_tb testbench module with clock, reset, DUT, reference window model, monitor, timeout
`timescale 1ns/10ps
`default_nettype none

module countrate_tb;

    localparam int NUM_LANES    = countrate_pkg::DEFAULT_NUM_LANES;
    localparam int NUM_CHANNELS = countrate_pkg::DEFAULT_NUM_CHANNELS;
    localparam int CLK_PERIOD   = 4;
    localparam int SAMPLE_DELAY = 1;
    // six tests stay near 1,500 cycles even with every random gap stalling, so 4,000 leaves margin
    localparam int MAX_CYCLES   = 4000;

    typedef countrate_pkg::count_t [NUM_CHANNELS-1:0] snap_t;

    logic clk = 1'b0;
    logic rst_n;
    logic [NUM_LANES-1:0] tag_valid;
    countrate_pkg::tag_time_t [NUM_LANES-1:0] tag_time;
    countrate_pkg::channel_t [NUM_LANES-1:0] tag_channel;
    logic tag_ready;
    countrate_pkg::tag_time_t window_size;
    logic start;
    logic clear;
    snap_t count_data;
    logic count_valid;

    // beat under construction by the tests
    logic [NUM_LANES-1:0] stage_valid;
    countrate_pkg::tag_time_t [NUM_LANES-1:0] stage_time;
    countrate_pkg::channel_t [NUM_LANES-1:0] stage_chan;

    // reference model state with the bounds of the current window and the one after it
    logic model_armed;
    logic model_measuring;
    countrate_pkg::tag_time_t model_end;
    countrate_pkg::tag_time_t model_next;
    countrate_pkg::count_t model_count [NUM_CHANNELS];
    // expected snapshots in window order
    // the monitor walks them with its own read index
    snap_t exp_q [$];
    int exp_rd = 0;

    int errors = 0;
    int mon_errors = 0;
    int tests_run = 0;
    int snaps_seen = 0;
    int cycles = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    countrate_top #(
        .NUM_LANES    (NUM_LANES),
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .tag_valid_i  (tag_valid),
        .tag_time_i   (tag_time),
        .tag_channel_i(tag_channel),
        .tag_ready_o  (tag_ready),
        .window_size_i(window_size),
        .start_i      (start),
        .clear_i      (clear),
        .count_data_o (count_data),
        .count_valid_o(count_valid)
    );

    // true when t lies at or after bound
    // the difference keeps working across the wrap of the time range
    function automatic bit at_or_past(input countrate_pkg::tag_time_t t,
                                      input countrate_pkg::tag_time_t bound);
        countrate_pkg::tag_time_t diff;
        diff = t - bound;
        return ~diff[countrate_pkg::TAG_WIDTH-1];
    endfunction

    task automatic zero_expected_counts();
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            model_count[c] = '0;
        end
    endtask

    // current window becomes a snapshot and the next window becomes current
    task automatic close_expected_window(input countrate_pkg::tag_time_t size);
        snap_t snap;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            snap[c] = model_count[c];
        end
        exp_q.push_back(snap);
        zero_expected_counts();
        model_end  = model_next;
        model_next = model_next + size;
    endtask

    task automatic classify_tag(input countrate_pkg::tag_time_t t,
                                input countrate_pkg::channel_t ch,
                                input countrate_pkg::tag_time_t size);
        int idx;
        // windows skipped by a gap close empty
        while (at_or_past(t, model_next)) begin
            close_expected_window(size);
        end
        // a tag in the next window closes the current one
        if (at_or_past(t, model_end)) begin
            close_expected_window(size);
        end
        idx = int'(ch);
        // keep-alive channels move windows only
        if (idx < NUM_CHANNELS) begin
            model_count[idx] = model_count[idx] + 1;
        end
    endtask

    // applies the staged beat to the model
    // lane order is time order
    task automatic predict_beat();
        int first;
        first = -1;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (stage_valid[l] && first < 0) begin
                first = l;
            end
        end
        if (model_armed) begin
            // opening beat sets window 0 and is not counted
            if (first >= 0) begin
                model_end       = stage_time[first] + window_size;
                model_next      = stage_time[first] + window_size + window_size;
                model_armed     = 1'b0;
                model_measuring = 1'b1;
                zero_expected_counts();
            end
        end else if (model_measuring) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (stage_valid[l]) begin
                    classify_tag(stage_time[l], stage_chan[l], window_size);
                end
            end
        end
    endtask

    task automatic stage_lane(input int lane, input countrate_pkg::tag_time_t t, input int ch);
        stage_valid[lane] = 1'b1;
        stage_time[lane]  = t;
        stage_chan[lane]  = countrate_pkg::channel_t'(ch);
    endtask

    // drives the staged beat from a falling edge and holds it until accepted
    task automatic send_staged(output int stalls);
        bit accepted;
        predict_beat();
        tag_valid   = stage_valid;
        tag_time    = stage_time;
        tag_channel = stage_chan;
        stalls      = 0;
        accepted    = 1'b0;
        while (!accepted) begin
            #SAMPLE_DELAY;
            accepted = tag_ready;
            if (!accepted) begin
                stalls++;
            end
            @(negedge clk);
        end
        tag_valid   = '0;
        stage_valid = '0;
    endtask

    task automatic check_stalls(input int stalls, input int expected);
        if (stalls != expected) begin
            $display("tag_ready_o was low for %0d cycles where %0d were expected",
                     stalls, expected);
            errors++;
        end
    endtask

    task automatic start_run();
        start = 1'b1;
        @(negedge clk);
        start       = 1'b0;
        model_armed = 1'b1;
    endtask

    task automatic clear_run();
        clear = 1'b1;
        @(negedge clk);
        clear           = 1'b0;
        model_armed     = 1'b0;
        model_measuring = 1'b0;
        zero_expected_counts();
    endtask

    // waits until the monitor has seen every snapshot the model expects
    task automatic wait_snapshots();
        int waited;
        waited = 0;
        while (exp_rd < exp_q.size() && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd < exp_q.size()) begin
            $display("%0d snapshot(s) never arrived from the DUT", exp_q.size() - exp_rd);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        int total;
        total = errors + mon_errors;
        tests_run++;
        if (total == err_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d error(s)", name, total - err_before);
        end
    endtask

    // a keep-alive at the window end closes the last counted window
    task automatic close_and_report(input string name, input int err_before);
        int stalls;
        stage_lane(0, model_end, 63);
        send_staged(stalls);
        wait_snapshots();
        clear_run();
        report_test(name, err_before);
    endtask

`include "countrate_tests.svh"

    // snapshot monitor
    // data and valid are both registered so the edge value is stable
    always @(posedge clk) begin
        if (rst_n && count_valid) begin
            if (exp_rd >= exp_q.size()) begin
                $display("Snapshot at cycle %0d arrived with no window closed in the model",
                         cycles);
                mon_errors++;
            end else begin
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    if (count_data[c] !== exp_q[exp_rd][c]) begin
                        $display("Mismatch count_data_o[%0d] snap %0d: got 0x%08h, exp 0x%08h",
                                 c, exp_rd, count_data[c], exp_q[exp_rd][c]);
                        mon_errors++;
                    end
                end
                exp_rd++;
            end
            snaps_seen++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hca06));
        rst_n           = 1'b0;
        tag_valid       = '0;
        tag_time        = '0;
        tag_channel     = '0;
        window_size     = 64'd100;
        start           = 1'b0;
        clear           = 1'b0;
        stage_valid     = '0;
        stage_time      = '0;
        stage_chan      = '0;
        model_armed     = 1'b0;
        model_measuring = 1'b0;
        model_end       = '0;
        model_next      = '0;
        zero_expected_counts();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // idle after reset means ready high and no snapshot
        if (tag_ready !== 1'b1 || count_valid !== 1'b0) begin
            $display("after reset tag_ready_o or count_valid_o is not in its idle state");
            errors++;
        end
        count_basic_windows();
        split_beat_across_windows();
        stall_over_gap();
        pass_keep_alive_tags();
        resize_and_clear();
        drive_random_traffic();
        $display("%0d tests run, %0d snapshots checked, %0d errors",
                 tests_run, snaps_seen, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
